//--- hw/upsizer_pkg.sv
// ==========================================================
// AXI write upsizer package
// Widths, field types, burst and response codes and the
// address helpers shared by the upsizer blocks
// ==========================================================

package upsizer_pkg;

  // Narrow (manager) and wide (subordinate) data widths
  localparam int unsigned slv_data_width = 32;
  localparam int unsigned mst_data_width = 64;
  localparam int unsigned slv_strb_width = slv_data_width / 8;
  localparam int unsigned mst_strb_width = mst_data_width / 8;
  localparam int unsigned mst_max_size   = 3;
  localparam int unsigned addr_width     = 32;

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [7:0]                len_t;
  typedef logic [2:0]                size_t;
  typedef logic [1:0]                burst_t;
  typedef logic [1:0]                resp_t;
  typedef logic [slv_data_width-1:0] slv_data_t;
  typedef logic [slv_strb_width-1:0] slv_strb_t;
  typedef logic [mst_data_width-1:0] mst_data_t;
  typedef logic [mst_strb_width-1:0] mst_strb_t;

  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr  = 2'b01;
  localparam burst_t burst_wrap  = 2'b10;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // How a write burst is handled on its way to the wide side
  typedef enum logic [1:0] {
    mode_pass,
    mode_upsize,
    mode_error
  } wr_mode_e;

  // Clear the address bits below the given transfer size
  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return addr & ({addr_width{1'b1}} << size);
  endfunction

  // Address of the final beat of an INCR burst
  function automatic addr_t last_beat_addr(addr_t addr, size_t size, len_t len);
    return aligned_addr(addr, size) + (addr_t'(len) << size);
  endfunction

endpackage

//--- hw/aw_planner.sv
// ==========================================================
// AW planner
// Classifies a narrow write burst and works out the length
// and size the burst takes on the wide side
// ==========================================================

`timescale 1ns/1ns

module aw_planner import upsizer_pkg::*; (
  input  addr_t    slv_aw_addr_i,
  input  len_t     slv_aw_len_i,
  input  size_t    slv_aw_size_i,
  input  burst_t   slv_aw_burst_i,
  input  logic     slv_aw_modifiable_i,
  output wr_mode_e plan_mode_o,
  output len_t     plan_len_o,
  output size_t    plan_size_o
);

  addr_t start_wide;
  addr_t end_wide;
  addr_t span;
  logic  multi_beat;

  // First and last wide words touched by the burst
  assign start_wide = aligned_addr(slv_aw_addr_i, size_t'(mst_max_size));
  assign end_wide   = aligned_addr(last_beat_addr(slv_aw_addr_i, slv_aw_size_i, slv_aw_len_i),
                                   size_t'(mst_max_size));
  assign span       = (end_wide - start_wide) >> mst_max_size;
  assign multi_beat = (slv_aw_len_i != '0);

  always_comb begin
    plan_mode_o = mode_pass;
    plan_len_o  = slv_aw_len_i;
    plan_size_o = slv_aw_size_i;
    if (slv_aw_burst_i == burst_wrap && multi_beat) begin
      // Wrapping bursts cannot be repacked
      plan_mode_o = mode_error;
    end else if (slv_aw_burst_i == burst_incr && slv_aw_modifiable_i && multi_beat) begin
      plan_mode_o = mode_upsize;
      plan_len_o  = len_t'(span);
      plan_size_o = size_t'(mst_max_size);
    end
  end

endmodule

//--- hw/w_packer.sv
// ==========================================================
// W packer
// Holds the active write burst, issues the wide AW and
// steers narrow W beats into wide beats
// ==========================================================

`timescale 1ns/1ns

module w_packer import upsizer_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      slv_aw_valid_i,
  output logic      slv_aw_ready_o,
  input  addr_t     slv_aw_addr_i,
  input  len_t      slv_aw_len_i,
  input  size_t     slv_aw_size_i,
  input  burst_t    slv_aw_burst_i,
  input  wr_mode_e  plan_mode_i,
  input  len_t      plan_len_i,
  input  size_t     plan_size_i,
  input  logic      slv_w_valid_i,
  output logic      slv_w_ready_o,
  input  slv_data_t slv_w_data_i,
  input  slv_strb_t slv_w_strb_i,
  input  logic      slv_w_last_i,
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  output addr_t     mst_aw_addr_o,
  output len_t      mst_aw_len_o,
  output size_t     mst_aw_size_o,
  output burst_t    mst_aw_burst_o,
  output logic      mst_w_valid_o,
  input  logic      mst_w_ready_i,
  output mst_data_t mst_w_data_o,
  output mst_strb_t mst_w_strb_o,
  output logic      mst_w_last_o,
  input  logic      err_pending_i,
  output logic      err_done_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_pass,
    st_upsize,
    st_drop
  } state_e;

  state_e    state_q;
  logic      armed_q;
  logic      aw_valid_q;
  logic      w_valid_q;
  logic [8:0] remain_q;
  addr_t     aw_addr_q;
  len_t      aw_len_q;
  size_t     aw_size_q;
  burst_t    aw_burst_q;
  size_t     orig_size_q;
  addr_t     addr_q;
  mst_data_t w_data_q;
  mst_strb_t w_strb_q;
  logic      w_last_q;

  logic aw_hs, w_hs, mst_aw_hs, mst_w_hs;
  logic load, fire, final_beat, word_cross;
  addr_t incr_addr, next_addr;
  logic [mst_max_size-1:0] lane_off;
  logic [mst_max_size:0]   size_bytes;
  mst_data_t steer_data;
  mst_strb_t steer_strb;

  assign slv_aw_ready_o = armed_q && (state_q == st_idle) && !err_pending_i;
  assign slv_w_ready_o  = (state_q != st_idle) && !aw_valid_q && (remain_q != '0) &&
                          (!w_valid_q || mst_w_ready_i);

  assign aw_hs     = slv_aw_valid_i && slv_aw_ready_o;
  assign w_hs      = slv_w_valid_i && slv_w_ready_o;
  assign mst_aw_hs = aw_valid_q && mst_aw_ready_i;
  assign mst_w_hs  = w_valid_q && mst_w_ready_i;

  // Narrow address of the next beat
  assign incr_addr  = aligned_addr(addr_q, orig_size_q) + (addr_t'(1) << orig_size_q);
  assign next_addr  = (aw_burst_q == burst_incr) ? incr_addr : addr_q;
  assign word_cross = aligned_addr(next_addr, size_t'(mst_max_size)) !=
                      aligned_addr(addr_q, size_t'(mst_max_size));
  // Final beat by count, or by the manager's last flag
  assign final_beat = (remain_q == 9'd1) || slv_w_last_i;
  assign load       = w_hs && (state_q != st_drop);
  assign fire       = (state_q == st_pass) || final_beat || word_cross;
  assign err_done_o = w_hs && (state_q == st_drop) && final_beat;

  // Lane steering of the current narrow beat into the wide word
  always_comb begin
    lane_off   = addr_q[mst_max_size-1:0];
    size_bytes = (mst_max_size+1)'(1) << orig_size_q;
    steer_data = w_valid_q ? '0 : w_data_q;
    steer_strb = w_valid_q ? '0 : w_strb_q;
    for (int b = 0; b < mst_strb_width; b++) begin
      if ((mst_max_size'(b) >= lane_off) && ((mst_max_size'(b) - lane_off) < size_bytes) &&
          (b / slv_strb_width == int'(lane_off) / slv_strb_width)) begin
        steer_data[8*b +: 8] = slv_w_data_i[8*(b % slv_strb_width) +: 8];
        steer_strb[b]        = slv_w_strb_i[b % slv_strb_width];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= st_idle;
      armed_q    <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      remain_q   <= '0;
    end else begin
      armed_q <= 1'b1;
      if (aw_hs) begin
        remain_q <= {1'b0, slv_aw_len_i} + 9'd1;
        case (plan_mode_i)
          mode_error:  state_q <= st_drop;
          mode_upsize: state_q <= st_upsize;
          default:     state_q <= st_pass;
        endcase
        // Error bursts never reach the wide side
        aw_valid_q <= (plan_mode_i != mode_error);
      end else begin
        if (mst_aw_hs) begin
          aw_valid_q <= 1'b0;
        end
        if (w_hs) begin
          remain_q <= final_beat ? '0 : remain_q - 9'd1;
        end
        if (mst_w_hs) begin
          w_valid_q <= 1'b0;
        end
        if (load && fire) begin
          w_valid_q <= 1'b1;
        end
        if (err_done_o || (mst_w_hs && w_last_q)) begin
          state_q <= st_idle;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q   <= slv_aw_addr_i;
      aw_len_q    <= plan_len_i;
      aw_size_q   <= plan_size_i;
      aw_burst_q  <= slv_aw_burst_i;
      orig_size_q <= slv_aw_size_i;
      addr_q      <= slv_aw_addr_i;
      w_data_q    <= '0;
      w_strb_q    <= '0;
      w_last_q    <= 1'b0;
    end else if (load) begin
      addr_q   <= next_addr;
      w_data_q <= steer_data;
      w_strb_q <= steer_strb;
      w_last_q <= final_beat;
    end else if (mst_w_hs) begin
      // A sent wide word leaves no lanes behind for the next one
      w_data_q <= '0;
      w_strb_q <= '0;
    end
  end

  assign mst_aw_valid_o = aw_valid_q;
  assign mst_aw_addr_o  = aw_addr_q;
  assign mst_aw_len_o   = aw_len_q;
  assign mst_aw_size_o  = aw_size_q;
  assign mst_aw_burst_o = aw_burst_q;
  assign mst_w_valid_o  = w_valid_q;
  assign mst_w_data_o   = w_data_q;
  assign mst_w_strb_o   = w_strb_q;
  assign mst_w_last_o   = w_last_q;

endmodule

//--- hw/b_merger.sv
// ==========================================================
// B merger
// Forwards wide-side B responses and inserts a local
// SLVERR response for absorbed error bursts
// ==========================================================

`timescale 1ns/1ns

module b_merger import upsizer_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  mst_b_valid_i,
  output logic  mst_b_ready_o,
  input  resp_t mst_b_resp_i,
  output logic  slv_b_valid_o,
  input  logic  slv_b_ready_i,
  output resp_t slv_b_resp_o,
  input  logic  err_done_i,
  output logic  err_pending_o
);

  logic pending_q;

  // Local error response waits here until the manager takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (err_done_i) begin
      pending_q <= 1'b1;
    end else if (pending_q && slv_b_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  assign slv_b_valid_o = pending_q || mst_b_valid_i;
  assign slv_b_resp_o  = pending_q ? resp_slverr : mst_b_resp_i;
  // Wide B is held off while the local response is shown
  assign mst_b_ready_o = slv_b_ready_i && !pending_q;
  assign err_pending_o = pending_q;

endmodule

//--- hw/dw_upsizer.sv
// ==========================================================
// AXI write data-width upsizer, 32-bit to 64-bit
// Single outstanding burst on the AW, W and B channels
// ==========================================================

`timescale 1ns/1ns

module dw_upsizer import upsizer_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Narrow manager side
  input  logic      slv_aw_valid_i,
  output logic      slv_aw_ready_o,
  input  addr_t     slv_aw_addr_i,
  input  len_t      slv_aw_len_i,
  input  size_t     slv_aw_size_i,
  input  burst_t    slv_aw_burst_i,
  input  logic      slv_aw_modifiable_i,
  input  logic      slv_w_valid_i,
  output logic      slv_w_ready_o,
  input  slv_data_t slv_w_data_i,
  input  slv_strb_t slv_w_strb_i,
  input  logic      slv_w_last_i,
  output logic      slv_b_valid_o,
  input  logic      slv_b_ready_i,
  output resp_t     slv_b_resp_o,
  // Wide subordinate side
  output logic      mst_aw_valid_o,
  input  logic      mst_aw_ready_i,
  output addr_t     mst_aw_addr_o,
  output len_t      mst_aw_len_o,
  output size_t     mst_aw_size_o,
  output burst_t    mst_aw_burst_o,
  output logic      mst_w_valid_o,
  input  logic      mst_w_ready_i,
  output mst_data_t mst_w_data_o,
  output mst_strb_t mst_w_strb_o,
  output logic      mst_w_last_o,
  input  logic      mst_b_valid_i,
  output logic      mst_b_ready_o,
  input  resp_t     mst_b_resp_i
);

  wr_mode_e plan_mode;
  len_t     plan_len;
  size_t    plan_size;
  logic     err_done;
  logic     err_pending;

  aw_planner aw_planner_i (
    .slv_aw_addr_i       (slv_aw_addr_i),
    .slv_aw_len_i        (slv_aw_len_i),
    .slv_aw_size_i       (slv_aw_size_i),
    .slv_aw_burst_i      (slv_aw_burst_i),
    .slv_aw_modifiable_i (slv_aw_modifiable_i),
    .plan_mode_o         (plan_mode),
    .plan_len_o          (plan_len),
    .plan_size_o         (plan_size)
  );

  w_packer w_packer_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_size_i  (slv_aw_size_i),
    .slv_aw_burst_i (slv_aw_burst_i),
    .plan_mode_i    (plan_mode),
    .plan_len_i     (plan_len),
    .plan_size_i    (plan_size),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_strb_i   (slv_w_strb_i),
    .slv_w_last_i   (slv_w_last_i),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_burst_o (mst_aw_burst_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_w_data_o   (mst_w_data_o),
    .mst_w_strb_o   (mst_w_strb_o),
    .mst_w_last_o   (mst_w_last_o),
    .err_pending_i  (err_pending),
    .err_done_o     (err_done)
  );

  b_merger b_merger_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .mst_b_resp_i  (mst_b_resp_i),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .slv_b_resp_o  (slv_b_resp_o),
    .err_done_i    (err_done),
    .err_pending_o (err_pending)
  );

endmodule

//--- dv/upsizer_properties.sv
// ==========================================================
// Handshake properties of the AXI write upsizer
// Bound to the top level, valid must hold until ready
// ==========================================================

`timescale 1ns/1ns

module upsizer_properties import upsizer_pkg::*; (
  input logic   clk_i,
  input logic   rst_ni,
  input logic   slv_aw_valid_i,
  input logic   slv_aw_ready_o,
  input len_t   slv_aw_len_i,
  input burst_t slv_aw_burst_i,
  input logic   slv_w_valid_i,
  input logic   slv_w_ready_o,
  input logic   mst_aw_valid_o,
  input logic   mst_aw_ready_i,
  input addr_t  mst_aw_addr_o,
  input logic   mst_w_valid_o,
  input logic   mst_w_ready_i,
  input logic   mst_w_last_o
);

  slv_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i && !slv_aw_ready_o |=> slv_aw_valid_i) else $error("narrow AW dropped");
  slv_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_w_valid_i && !slv_w_ready_o |=> slv_w_valid_i) else $error("narrow W dropped");
  mst_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_addr_o))
    else $error("wide AW dropped or changed");
  mst_w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_last_o))
    else $error("wide W dropped or changed");
  // Multi-beat WRAP bursts stay on the narrow side
  wrap_no_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_aw_valid_i && slv_aw_ready_o && slv_aw_burst_i == burst_wrap && slv_aw_len_i != '0
    |=> !mst_aw_valid_o) else $error("wide AW raised for a WRAP burst");

endmodule

bind dw_upsizer upsizer_properties props_i (.*);

//--- dv/tb_dw_upsizer.sv
// ==========================================================
// Testbench for the AXI write upsizer
// Burst table, downstream memory model, reference memory
// and watchdog around the DUT
// ==========================================================

`timescale 1ns/1ns

module tb_dw_upsizer import upsizer_pkg::*; ();

  localparam int n_rows     = 11;
  localparam int row_cycles = 60;
  localparam int period     = 100;

  typedef struct {
    int unsigned addr;
    int unsigned len;
    int unsigned size;
    int unsigned burst;
    int unsigned modif;
    int unsigned exp_len;
    int unsigned exp_size;
    int unsigned exp_beats;
    int unsigned exp_resp;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_aw_modifiable_i;
  addr_t slv_aw_addr_i;
  len_t slv_aw_len_i;
  size_t slv_aw_size_i;
  burst_t slv_aw_burst_i;
  logic slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  slv_data_t slv_w_data_i;
  slv_strb_t slv_w_strb_i;
  logic slv_b_valid_o, slv_b_ready_i;
  resp_t slv_b_resp_o;
  logic mst_aw_valid_o, mst_aw_ready_i;
  addr_t mst_aw_addr_o;
  len_t mst_aw_len_o;
  size_t mst_aw_size_o;
  burst_t mst_aw_burst_o;
  logic mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  mst_data_t mst_w_data_o;
  mst_strb_t mst_w_strb_o;
  logic mst_b_valid_i, mst_b_ready_o;
  resp_t mst_b_resp_i;

  row_t rows [n_rows];
  logic [7:0] mem [4096];
  logic mem_valid [4096];
  logic [7:0] ref_mem [4096];
  logic ref_valid [4096];
  logic [31:0] data_seed;
  logic [31:0] ready_seed;
  int aw_count, w_count, b_count;
  int unsigned dn_addr, dn_len, dn_size, dn_burst, dn_beat;
  resp_t last_resp;

  dw_upsizer dut_i (.*);

  always #(period / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Address of beat n where every beat after the first is size aligned
  function automatic int unsigned beat_address(int unsigned start, int unsigned size,
                                               int unsigned burst, int unsigned n);
    if (burst == 0 || n == 0) begin
      return start;
    end
    return ((start >> size) << size) + (n << size);
  endfunction

  // Narrow byte lanes that are active for a beat at this address
  function automatic logic [3:0] lane_strobes(int unsigned a, int unsigned size);
    logic [3:0] s;
    int unsigned hi;
    s  = '0;
    hi = (((a >> size) << size) % 4) + (1 << size) - 1;
    for (int j = 0; j < 4; j++) begin
      if (j >= int'(a % 4) && j <= int'(hi)) begin
        s[j] = 1'b1;
      end
    end
    return s;
  endfunction

  task automatic check(input string name, input int unsigned exp, input int unsigned act);
    if (exp != act) begin
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic load_table();
    // addr, len, size, burst, modifiable, wide len, wide size, wide beats, resp
    rows[0]  = '{32'h000, 3, 2, 1, 1, 1, 3, 2, 0};
    rows[1]  = '{32'h104, 4, 2, 1, 1, 2, 3, 3, 0};
    rows[2]  = '{32'h202, 2, 2, 1, 1, 1, 3, 2, 0};
    rows[3]  = '{32'h300, 7, 1, 1, 1, 1, 3, 2, 0};
    rows[4]  = '{32'h400, 3, 2, 0, 1, 3, 2, 4, 0};
    rows[5]  = '{32'h504, 0, 2, 1, 1, 0, 2, 1, 0};
    rows[6]  = '{32'h600, 3, 2, 1, 0, 3, 2, 4, 0};
    rows[7]  = '{32'h700, 3, 2, 2, 1, 0, 0, 0, 2};
    rows[8]  = '{32'h800, 0, 2, 2, 1, 0, 2, 1, 0};
    rows[9]  = '{32'h900, 15, 2, 1, 1, 7, 3, 8, 0};
    rows[10] = '{32'ha06, 2, 1, 1, 1, 1, 3, 2, 0};
  endtask

  // Downstream subordinate with a byte memory and random W back-pressure
  always @(posedge clk_i) begin
    int unsigned a;
    ready_seed = xorshift(ready_seed);
    mst_w_ready_i <= ready_seed[0] | ready_seed[1];
    if (slv_b_valid_o && slv_b_ready_i) begin
      b_count   = b_count + 1;
      last_resp = slv_b_resp_o;
    end
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      aw_count = aw_count + 1;
      dn_addr  = mst_aw_addr_o;
      dn_len   = mst_aw_len_o;
      dn_size  = mst_aw_size_o;
      dn_burst = mst_aw_burst_o;
      dn_beat  = 0;
    end
    if (mst_w_valid_o && mst_w_ready_i) begin
      w_count = w_count + 1;
      a = beat_address(dn_addr, dn_size, dn_burst, dn_beat) & ~32'd7;
      for (int l = 0; l < 8; l++) begin
        if (mst_w_strb_o[l]) begin
          mem[(a + l) % 4096]       = mst_w_data_o[8*l +: 8];
          mem_valid[(a + l) % 4096] = 1'b1;
        end
      end
      check("wide last", (dn_beat == dn_len), mst_w_last_o);
      if (dn_beat == dn_len) begin
        mst_b_valid_i <= 1'b1;
      end
      dn_beat = dn_beat + 1;
    end
    if (mst_b_valid_i && mst_b_ready_o) begin
      mst_b_valid_i <= 1'b0;
    end
  end

  task automatic run_row(input int r);
    int aw0, w0, b0;
    int unsigned a;
    logic [31:0] d;
    logic [3:0] s;
    string name;
    name = $sformatf("row %0d", r);
    aw0  = aw_count;
    w0   = w_count;
    b0   = b_count;
    @(posedge clk_i);
    slv_aw_valid_i      <= 1'b1;
    slv_aw_addr_i       <= rows[r].addr;
    slv_aw_len_i        <= len_t'(rows[r].len);
    slv_aw_size_i       <= size_t'(rows[r].size);
    slv_aw_burst_i      <= burst_t'(rows[r].burst);
    slv_aw_modifiable_i <= rows[r].modif[0];
    do @(posedge clk_i); while (!slv_aw_ready_o);
    slv_aw_valid_i <= 1'b0;
    for (int unsigned n = 0; n <= rows[r].len; n++) begin
      a         = beat_address(rows[r].addr, rows[r].size, rows[r].burst, n);
      data_seed = xorshift(data_seed);
      d         = data_seed;
      s         = lane_strobes(a, rows[r].size);
      slv_w_valid_i <= 1'b1;
      slv_w_data_i  <= d;
      slv_w_strb_i  <= s;
      slv_w_last_i  <= (n == rows[r].len);
      do @(posedge clk_i); while (!slv_w_ready_o);
      if (rows[r].exp_beats != 0) begin
        for (int j = 0; j < 4; j++) begin
          if (s[j]) begin
            ref_mem[((a & ~32'd3) + j) % 4096]   = d[8*j +: 8];
            ref_valid[((a & ~32'd3) + j) % 4096] = 1'b1;
          end
        end
      end
    end
    slv_w_valid_i <= 1'b0;
    while (b_count == b0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    check({name, " B count"}, 1, b_count - b0);
    check({name, " B resp"}, rows[r].exp_resp, last_resp);
    check({name, " wide AW count"}, (rows[r].exp_beats != 0), aw_count - aw0);
    check({name, " wide beats"}, rows[r].exp_beats, w_count - w0);
    if (rows[r].exp_beats != 0) begin
      check({name, " wide addr"}, rows[r].addr, dn_addr);
      check({name, " wide burst"}, rows[r].burst, dn_burst);
      check({name, " wide len"}, rows[r].exp_len, dn_len);
      check({name, " wide size"}, rows[r].exp_size, dn_size);
    end
    // Every byte written on the narrow side must sit at its address downstream
    for (int unsigned k = rows[r].addr & ~32'hff; k < (rows[r].addr & ~32'hff) + 256; k++) begin
      if (ref_valid[k]) begin
        check($sformatf("%s written at %0h", name, k), 1, mem_valid[k]);
        check($sformatf("%s byte at %0h", name, k), ref_mem[k], mem[k]);
      end
    end
  endtask

  // Watchdog
  initial begin
    #((3 + n_rows * row_cycles) * period);
    $display("Timeout: the bursts did not complete in time");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_ni              = 1'b0;
    slv_aw_valid_i      = 1'b0;
    slv_aw_addr_i       = '0;
    slv_aw_len_i        = '0;
    slv_aw_size_i       = '0;
    slv_aw_burst_i      = '0;
    slv_aw_modifiable_i = 1'b0;
    slv_w_valid_i       = 1'b0;
    slv_w_data_i        = '0;
    slv_w_strb_i        = '0;
    slv_w_last_i        = 1'b0;
    slv_b_ready_i       = 1'b1;
    mst_aw_ready_i      = 1'b1;
    mst_w_ready_i       = 1'b0;
    mst_b_valid_i       = 1'b0;
    mst_b_resp_i        = resp_okay;
    data_seed           = 32'hd7d4_5cdd;
    ready_seed          = xorshift(32'hd7d4_5cdd);
    aw_count            = 0;
    w_count             = 0;
    b_count             = 0;
    for (int k = 0; k < 4096; k++) begin
      mem_valid[k] = 1'b0;
      ref_valid[k] = 1'b0;
    end
    load_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- tb.f
hw/upsizer_pkg.sv
hw/aw_planner.sv
hw/w_packer.sv
hw/b_merger.sv
hw/dw_upsizer.sv
dv/upsizer_properties.sv
dv/tb_dw_upsizer.sv

//--- run.sh
#!/bin/sh
# Build and run the upsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_dw_upsizer -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
